// ==== Makefile ====
TOOL     = verilator
TOP      = tb_exec_top
FILELIST = exec_top.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
SIM_ARGS = +verilator+error+limit+1000
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(filter %.sv,$(shell cat $(FILELIST)))
HDRS     = $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) -Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== exec_top.f ====
+incdir+hw
hw/exec_pkg.sv
hw/exec_if.sv
hw/int_alu.sv
hw/muldiv_unit.sv
hw/issue_retire.sv
hw/exec_top.sv
testbench/exec_top_checker.sv
testbench/tb_exec_top.sv

// ==== hw/exec_consts.svh ====
// word width, register address width and iteration count, included wherever these sizes are needed
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define XLEN 32

`define REG_AW 5

// one multiply or divide step per data bit
`define MD_STEPS 32

`endif

// ==== hw/exec_if.sv ====
// valid/ready link carrying one instruction from the issuer to a unit and its result back
`timescale 1ns/1ns
`include "exec_consts.svh"

interface exec_if import exec_pkg::*; ();

    // issue side
    logic              req_valid;
    logic              req_ready;
    exec_op_e          op;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    logic [`REG_AW-1:0] rd;

    // result side
    logic              res_valid;
    logic              res_ready;
    logic [`XLEN-1:0]  res_data;
    logic [`REG_AW-1:0] res_rd;

    modport issuer (
        output req_valid, op, a, b, rd, res_ready,
        input  req_ready, res_valid, res_data, res_rd
    );

    modport unit (
        input  req_valid, op, a, b, rd, res_ready,
        output req_ready, res_valid, res_data, res_rd
    );

endinterface

// ==== hw/exec_pkg.sv ====
// shared opcode, unit-class and multiply/divide state types for the execute back end and its testbench
package exec_pkg;

    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_and   = 5'd2,
        op_or    = 5'd3,
        op_xor   = 5'd4,
        op_nor   = 5'd5,
        op_slt   = 5'd6,
        op_sltu  = 5'd7,
        op_sll   = 5'd8,
        op_srl   = 5'd9,
        op_sra   = 5'd10,
        op_lui   = 5'd11,
        op_mult  = 5'd12,
        op_multu = 5'd13,
        op_div   = 5'd14,
        op_divu  = 5'd15,
        op_mfhi  = 5'd16,
        op_mflo  = 5'd17,
        op_mthi  = 5'd18,
        op_mtlo  = 5'd19
    } exec_op_e;

    typedef enum logic {
        unit_alu = 1'b0,
        unit_md  = 1'b1
    } unit_e;

    typedef enum logic [1:0] {
        md_idle    = 2'd0,
        md_mul_run = 2'd1,
        md_div_run = 2'd2,
        md_fixup   = 2'd3
    } md_state_e;

    // everything touching hi/lo goes to the multiply/divide unit
    function automatic unit_e unit_of(exec_op_e op);
        case (op)
            op_mult, op_multu, op_div, op_divu,
            op_mfhi, op_mflo, op_mthi, op_mtlo: return unit_md;
            default: return unit_alu;
        endcase
    endfunction

endpackage

// ==== hw/exec_top.sv ====
// top of the execute back end, joins the input and writeback ports to the ALU and multiply/divide unit
`timescale 1ns/1ns
`include "exec_consts.svh"

module exec_top import exec_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  exec_op_e           in_op,
    input  logic [`XLEN-1:0]   in_a,
    input  logic [`XLEN-1:0]   in_b,
    input  logic [`REG_AW-1:0] in_rd,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`XLEN-1:0]   out_data,
    output logic [`REG_AW-1:0] out_rd
);

    exec_if alu_bus ();
    exec_if md_bus ();

    issue_retire u_issue_retire (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_rd     (in_rd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_rd    (out_rd),
        .alu_bus   (alu_bus.issuer),
        .md_bus    (md_bus.issuer)
    );

    int_alu u_int_alu (
        .clk   (clk),
        .reset (reset),
        .bus   (alu_bus.unit)
    );

    muldiv_unit u_muldiv_unit (
        .clk   (clk),
        .reset (reset),
        .bus   (md_bus.unit)
    );

endmodule

// ==== hw/int_alu.sv ====
// single-cycle integer ALU behind an exec_if unit port, result held in a one-entry register
`timescale 1ns/1ns
`include "exec_consts.svh"

module int_alu import exec_pkg::*; (
    input  logic clk,
    input  logic reset,
    exec_if.unit bus
);

    logic [`XLEN-1:0]         alu_y;
    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     req_fire;

    assign shamt    = bus.b[$clog2(`XLEN)-1:0];
    assign req_fire = bus.req_valid && bus.req_ready;

    // free slot, or the held result leaves this cycle
    assign bus.req_ready = !bus.res_valid || bus.res_ready;

    always_comb begin
        case (bus.op)
            op_add:  alu_y = bus.a + bus.b;
            op_sub:  alu_y = bus.a - bus.b;
            op_and:  alu_y = bus.a & bus.b;
            op_or:   alu_y = bus.a | bus.b;
            op_xor:  alu_y = bus.a ^ bus.b;
            op_nor:  alu_y = ~(bus.a | bus.b);
            op_slt:  alu_y = {{(`XLEN-1){1'b0}}, ($signed(bus.a) < $signed(bus.b))};
            op_sltu: alu_y = {{(`XLEN-1){1'b0}}, (bus.a < bus.b)};
            op_sll:  alu_y = bus.a << shamt;
            op_srl:  alu_y = bus.a >> shamt;
            op_sra:  alu_y = $signed(bus.a) >>> shamt;
            op_lui:  alu_y = {bus.b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};
            default: alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.res_valid <= 1'b0;
        end else if (req_fire) begin
            bus.res_valid <= 1'b1;
        end else if (bus.res_ready) begin
            bus.res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            bus.res_data <= alu_y;
            bus.res_rd   <= bus.rd;
        end
    end

endmodule

// ==== hw/issue_retire.sv ====
// steers each input instruction to the ALU or multiply/divide bus and merges their results into out_*
`timescale 1ns/1ns
`include "exec_consts.svh"

module issue_retire import exec_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  exec_op_e           in_op,
    input  logic [`XLEN-1:0]   in_a,
    input  logic [`XLEN-1:0]   in_b,
    input  logic [`REG_AW-1:0] in_rd,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`XLEN-1:0]   out_data,
    output logic [`REG_AW-1:0] out_rd,
    exec_if.issuer             alu_bus,
    exec_if.issuer             md_bus
);

    unit_e in_unit;
    logic  alu_clear;
    logic  md_clear;
    logic  drain;
    logic  alu_take;
    logic  md_take;

    assign in_unit = unit_of(in_op);

    // a result still parked in the other unit is older, so hold issue until it retires
    assign alu_clear = !alu_bus.res_valid || alu_bus.res_ready;
    assign md_clear  = !md_bus.res_valid || md_bus.res_ready;

    assign alu_bus.req_valid = in_valid && (in_unit == unit_alu) && md_clear;
    assign md_bus.req_valid  = in_valid && (in_unit == unit_md) && alu_clear;
    assign in_ready = (in_unit == unit_alu) ? (alu_bus.req_ready && md_clear)
                                            : (md_bus.req_ready && alu_clear);

    assign alu_bus.op = in_op;
    assign alu_bus.a  = in_a;
    assign alu_bus.b  = in_b;
    assign alu_bus.rd = in_rd;
    assign md_bus.op  = in_op;
    assign md_bus.a   = in_a;
    assign md_bus.b   = in_b;
    assign md_bus.rd  = in_rd;

    // output register free or emptied this cycle
    assign drain             = !out_valid || out_ready;
    assign alu_bus.res_ready = drain;
    assign md_bus.res_ready  = drain;
    assign alu_take          = alu_bus.res_valid && drain;
    assign md_take           = md_bus.res_valid && drain;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (drain) begin
            out_valid <= alu_take || md_take;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_take) begin
            out_data <= alu_bus.res_data;
            out_rd   <= alu_bus.res_rd;
        end else if (md_take) begin
            out_data <= md_bus.res_data;
            out_rd   <= md_bus.res_rd;
        end
    end

endmodule

// ==== hw/muldiv_unit.sv ====
// iterative multiply/divide unit holding hi and lo, serves mult/div and the hi/lo moves over exec_if
`timescale 1ns/1ns
`include "exec_consts.svh"

module muldiv_unit import exec_pkg::*; (
    input  logic clk,
    input  logic reset,
    exec_if.unit bus
);

    md_state_e                  state;
    logic [$clog2(`MD_STEPS)-1:0] step_cnt;
    logic [`XLEN-1:0]           hi;
    logic [`XLEN-1:0]           lo;
    // multiplicand or divisor magnitude
    logic [`XLEN-1:0]           opnd_b;
    logic                       div_mode;
    logic                       neg_q;
    logic                       neg_r;

    logic                       req_fire;
    logic                       signed_op;
    logic [`XLEN-1:0]           a_mag;
    logic [`XLEN-1:0]           b_mag;
    logic [`XLEN:0]             mul_sum;
    logic [`XLEN:0]             div_trial;
    logic                       last_step;

    assign bus.req_ready = (state == md_idle) && (!bus.res_valid || bus.res_ready);
    assign req_fire      = bus.req_valid && bus.req_ready;

    assign signed_op = (bus.op == op_mult) || (bus.op == op_div);
    assign a_mag     = (signed_op && bus.a[`XLEN-1]) ? -bus.a : bus.a;
    assign b_mag     = (signed_op && bus.b[`XLEN-1]) ? -bus.b : bus.b;

    // shift-add step with hi accumulating and lo shifting out the multiplier
    assign mul_sum   = {1'b0, hi} + (lo[0] ? {1'b0, opnd_b} : {(`XLEN+1){1'b0}});
    // restoring step keeps the old partial remainder on a borrow in the top bit
    assign div_trial = {hi, lo[`XLEN-1]} - {1'b0, opnd_b};
    assign last_step = (step_cnt == ($clog2(`MD_STEPS))'(`MD_STEPS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= md_idle;
            step_cnt      <= '0;
            bus.res_valid <= 1'b0;
        end else begin
            if (bus.res_ready) begin
                bus.res_valid <= 1'b0;
            end
            case (state)
                md_idle: begin
                    if (req_fire) begin
                        case (bus.op)
                            op_mult, op_multu: state <= md_mul_run;
                            op_div, op_divu:   state <= md_div_run;
                            op_mfhi, op_mflo:  bus.res_valid <= 1'b1;
                            default: ;
                        endcase
                    end
                end
                md_mul_run, md_div_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (last_step) begin
                        step_cnt <= '0;
                        state    <= md_fixup;
                    end
                end
                default: state <= md_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            md_idle: begin
                if (req_fire) begin
                    case (bus.op)
                        op_mult, op_multu: begin
                            hi       <= '0;
                            lo       <= b_mag;
                            opnd_b   <= a_mag;
                            div_mode <= 1'b0;
                            neg_q    <= signed_op && (bus.a[`XLEN-1] ^ bus.b[`XLEN-1]);
                        end
                        op_div, op_divu: begin
                            hi       <= '0;
                            lo       <= a_mag;
                            opnd_b   <= b_mag;
                            div_mode <= 1'b1;
                            // zero divisor keeps the all-ones quotient
                            neg_q    <= signed_op && (bus.a[`XLEN-1] ^ bus.b[`XLEN-1])
                                        && (bus.b != '0);
                            neg_r    <= signed_op && bus.a[`XLEN-1];
                        end
                        op_mfhi: begin
                            bus.res_data <= hi;
                            bus.res_rd   <= bus.rd;
                        end
                        op_mflo: begin
                            bus.res_data <= lo;
                            bus.res_rd   <= bus.rd;
                        end
                        op_mthi: hi <= bus.a;
                        op_mtlo: lo <= bus.a;
                        default: ;
                    endcase
                end
            end
            md_mul_run: begin
                {hi, lo} <= {mul_sum, lo[`XLEN-1:1]};
            end
            md_div_run: begin
                if (!div_trial[`XLEN]) begin
                    hi <= div_trial[`XLEN-1:0];
                    lo <= {lo[`XLEN-2:0], 1'b1};
                end else begin
                    hi <= {hi[`XLEN-2:0], lo[`XLEN-1]};
                    lo <= {lo[`XLEN-2:0], 1'b0};
                end
            end
            default: begin
                // quotient truncated toward zero and remainder signed like the dividend
                if (div_mode) begin
                    if (neg_q) lo <= -lo;
                    if (neg_r) hi <= -hi;
                end else if (neg_q) begin
                    {hi, lo} <= -{hi, lo};
                end
            end
        endcase
    end

endmodule

// ==== testbench/exec_top_checker.sv ====
// port protocol assertions for the execute back end, bound into exec_top
`timescale 1ns/1ns
`include "exec_consts.svh"

module exec_top_checker (
    input logic               clk,
    input logic               reset,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input logic [`XLEN-1:0]   out_data,
    input logic [`REG_AW-1:0] out_rd
);

    int stall_cnt;
    int reset_fails = 0;
    int stable_fails = 0;
    int stall_fails = 0;
    int fail_cnt;

    assign fail_cnt = reset_fails + stable_fails + stall_fails;

    // cycles with issue blocked while writeback is free to drain
    always_ff @(posedge clk) begin
        if (reset || in_ready || !out_ready) begin
            stall_cnt <= 0;
        end else begin
            stall_cnt <= stall_cnt + 1;
        end
    end

    out_empty_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            reset_fails++;
        end

    out_held_when_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_rd))
        else begin
            $error("writeback payload changed while stalled");
            stable_fails++;
        end

    issue_not_starved: assert property (@(posedge clk) disable iff (reset)
        stall_cnt <= `MD_STEPS + 4)
        else begin
            $error("in_ready stuck low with out_ready high");
            stall_fails++;
        end

endmodule

bind exec_top exec_top_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_rd    (out_rd)
);

// ==== testbench/tb_exec_top.sv ====
// self-checking testbench for exec_top, directed and random streams checked against a hi/lo model
`timescale 1ns/1ns
`include "exec_consts.svh"

module tb_exec_top import exec_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic               in_ready;
    exec_op_e           in_op;
    logic [`XLEN-1:0]   in_a;
    logic [`XLEN-1:0]   in_b;
    logic [`REG_AW-1:0] in_rd;
    logic               out_valid;
    logic               out_ready = 1'b1;
    logic [`XLEN-1:0]   out_data;
    logic [`REG_AW-1:0] out_rd;

    int    seed = 32'h2648a04c;
    string test_name = "reset";
    int    test_count = 0;
    int    check_count = 0;
    int    error_count = 0;
    int    mismatch_count = 0;
    int    checks_at_start;
    int    errors_at_start;
    logic  aborted = 1'b0;
    logic  bp_on = 1'b0;

    // expected writeback entries {rd, data} in issue order
    logic [`REG_AW+`XLEN-1:0] exp_q[$];
    logic [`XLEN-1:0]         m_hi;
    logic [`XLEN-1:0]         m_lo;
    logic [`XLEN-1:0]         edge_vals [8] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000,
                                                 32'h7fffffff, 32'hfffffffe, 32'h80000001,
                                                 32'h0000ffff};

    exec_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (bp_on) begin
            out_ready = (rnd() % 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        logic [`REG_AW+`XLEN-1:0] want;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("test %s: output with nothing expected, rd %0d data %h",
                         test_name, out_rd, out_data);
                mismatch_count++;
            end else begin
                want = exp_q.pop_front();
                check_count++;
                result_matches: assert ({out_rd, out_data} == want) else begin
                    $display("Error: test %s expected rd %0d data %h, actual rd %0d data %h",
                             test_name, want[`REG_AW+`XLEN-1:`XLEN], want[`XLEN-1:0],
                             out_rd, out_data);
                    mismatch_count++;
                end
            end
        end
    end

    function automatic logic [`XLEN-1:0] rnd();
        return $random(seed);
    endfunction

    // edge values half of the time
    function automatic logic [`XLEN-1:0] pick_operand();
        logic [`XLEN-1:0] r;
        r = rnd();
        if (r[0]) begin
            return edge_vals[r[3:1]];
        end
        return rnd();
    endfunction

    function automatic logic [`XLEN-1:0] alu_expect(exec_op_e op, logic [`XLEN-1:0] a,
                                                    logic [`XLEN-1:0] b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_slt:  return (sa < sb) ? 1 : 0;
            op_sltu: return (a < b) ? 1 : 0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return sa >>> b[4:0];
            op_lui:  return b << 16;
            default: return 0;
        endcase
    endfunction

    task automatic model(input exec_op_e op, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic [`REG_AW-1:0] rd);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        longint          q;
        longint          r;
        sa = {{`XLEN{a[`XLEN-1]}}, a};
        sb = {{`XLEN{b[`XLEN-1]}}, b};
        ua = {{`XLEN{1'b0}}, a};
        ub = {{`XLEN{1'b0}}, b};
        case (op)
            op_mult:  {m_hi, m_lo} = sa * sb;
            op_multu: {m_hi, m_lo} = ua * ub;
            op_div, op_divu: begin
                if (b == 0) begin
                    m_lo = '1;
                    m_hi = a;
                end else begin
                    // 64-bit math keeps the most negative quotient exact
                    q    = (op == op_div) ? sa / sb : longint'(ua / ub);
                    r    = (op == op_div) ? sa % sb : longint'(ua % ub);
                    m_lo = q[`XLEN-1:0];
                    m_hi = r[`XLEN-1:0];
                end
            end
            op_mfhi:  exp_q.push_back({rd, m_hi});
            op_mflo:  exp_q.push_back({rd, m_lo});
            op_mthi:  m_hi = a;
            op_mtlo:  m_lo = a;
            default:  exp_q.push_back({rd, alu_expect(op, a, b)});
        endcase
    endtask

    task automatic issue(input exec_op_e op, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic [`REG_AW-1:0] rd);
        int waited;
        if (aborted) return;
        @(negedge clk);
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        in_rd    = rd;
        waited   = 0;
        @(posedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (in_ready) begin
            model(op, a, b, rd);
        end else begin
            $display("test %s: %s was never accepted", test_name, op.name());
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic md_and_read(input exec_op_e op, input logic [`XLEN-1:0] a,
                               input logic [`XLEN-1:0] b);
        issue(op, a, b, 5'(rnd()));
        issue(op_mfhi, rnd(), rnd(), 5'(rnd()));
        issue(op_mflo, rnd(), rnd(), 5'(rnd()));
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = check_count;
        errors_at_start = error_count + mismatch_count;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        if (!aborted) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        while (exp_q.size() != 0 && waited < WAIT_LIMIT && !aborted) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0 && !aborted) begin
            $display("test %s: %0d results never came out", test_name, exp_q.size());
            error_count++;
            aborted = 1'b1;
        end
        // room for a stray extra result to show up
        if (!aborted) begin
            repeat (3) @(posedge clk);
        end
        test_count++;
        $display("test %s: %0d checks, %0d errors", test_name, check_count - checks_at_start,
                 error_count + mismatch_count - errors_at_start);
    endtask

    initial begin
        int         i;
        int         j;
        int         total;
        logic [4:0] k;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = op_add;
        in_a     = '0;
        in_b     = '0;
        in_rd    = '0;
        m_hi     = '0;
        m_lo     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("alu_ops");
        issue(op_slt, 32'h80000000, 32'h7fffffff, 5'd1);
        issue(op_sltu, 32'h80000000, 32'h7fffffff, 5'd2);
        issue(op_slt, 32'hffffffff, 32'h00000001, 5'd3);
        issue(op_sltu, 32'hffffffff, 32'h00000001, 5'd4);
        issue(op_slt, 32'h7fffffff, 32'h7fffffff, 5'd5);
        for (i = 0; i < 60; i++) begin
            k = 5'(rnd() % 12);
            issue(exec_op_e'(k), pick_operand(), pick_operand(), 5'(rnd()));
        end
        finish_test();

        start_test("mul_hilo");
        md_and_read(op_mult, 32'h80000000, 32'h80000000);
        md_and_read(op_multu, 32'hffffffff, 32'hffffffff);
        md_and_read(op_mult, 32'hffffffff, 32'h7fffffff);
        for (i = 0; i < 16; i++) begin
            md_and_read(i[0] ? op_multu : op_mult, pick_operand(), pick_operand());
        end
        finish_test();

        start_test("div_hilo");
        md_and_read(op_div, 32'hfffffff9, 32'h00000002);
        md_and_read(op_div, 32'h00000007, 32'hfffffffe);
        md_and_read(op_div, 32'hfffffff9, 32'hfffffffe);
        md_and_read(op_div, 32'h80000000, 32'hffffffff);
        md_and_read(op_div, 32'hfffffffb, 32'h00000000);
        md_and_read(op_divu, 32'h00000005, 32'h00000000);
        md_and_read(op_divu, 32'hffffffff, 32'h00000003);
        for (i = 0; i < 16; i++) begin
            md_and_read(i[0] ? op_divu : op_div, pick_operand(), pick_operand());
        end
        finish_test();

        start_test("move_to_hilo");
        for (i = 0; i < 6; i++) begin
            issue(op_mthi, rnd(), rnd(), 5'(rnd()));
            issue(op_mtlo, rnd(), rnd(), 5'(rnd()));
            issue(op_mfhi, rnd(), rnd(), 5'(rnd()));
            issue(op_mflo, rnd(), rnd(), 5'(rnd()));
        end
        finish_test();

        start_test("overlap");
        for (i = 0; i < 3; i++) begin
            issue(op_div, rnd(), pick_operand(), 5'(rnd()));
            for (j = 0; j < 8; j++) begin
                k = 5'(rnd() % 12);
                issue(exec_op_e'(k), pick_operand(), pick_operand(), 5'(rnd()));
            end
            issue(op_mflo, rnd(), rnd(), 5'(rnd()));
            issue(op_mfhi, rnd(), rnd(), 5'(rnd()));
        end
        finish_test();

        start_test("backpressure");
        bp_on = 1'b1;
        for (i = 0; i < 120; i++) begin
            k = 5'(rnd() % 20);
            issue(exec_op_e'(k), pick_operand(), pick_operand(), 5'(rnd()));
        end
        finish_test();
        bp_on = 1'b0;

        total = error_count + mismatch_count + UUT.u_checker.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
